// ==== hw/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // register file addressing, x0 to x31
    localparam int REG_ADDR_W = 5;

    localparam int DATA_W     = 32;             // operand and result width

    // forwarding vector, one bit per source stage
    localparam int BP_W       = 4;

    // bit positions, youngest writer at the lowest index
    localparam int BP_ALU2    = 0;              // result leaving alu2
    localparam int BP_MEMORY  = 1;
    localparam int BP_WRITE   = 2;
    localparam int BP_WR_BACK = 3;              // oldest, about to retire

endpackage

// ==== hw/rv_stage_if.sv ====
`timescale 1ns/1ps

interface rv_stage_if;

    logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs2;
    logic [rv_pipe_pkg::REG_ADDR_W-1:0] rd;
    logic                               reg_write;  // writes rd when it retires
    logic                               mem_rd;     // load, data late
    logic                               inst_sup;   // low for unsupported opcode

    // stage register side
    modport drv
    (
        output rs1,
        output rs2,
        output rd,
        output reg_write,
        output mem_rd,
        output inst_sup
    );

    // hazard logic side
    modport mon
    (
        input  rs1,
        input  rs2,
        input  rd,
        input  reg_write,
        input  mem_rd,
        input  inst_sup
    );

endinterface

// ==== hw/rv_tag_pipe.sv ====
`timescale 1ns/1ps

module rv_tag_pipe
(
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic [rv_pipe_pkg::REG_ADDR_W-1:0]  i_fetch_rs1,
    input  logic [rv_pipe_pkg::REG_ADDR_W-1:0]  i_fetch_rs2,
    input  logic [rv_pipe_pkg::REG_ADDR_W-1:0]  i_fetch_rd,
    input  logic                                i_fetch_reg_write,
    input  logic                                i_fetch_mem_rd,
    input  logic                                i_fetch_inst_sup,
    input  logic                                i_decode_stall,
    input  logic                                i_decode_flush,
    input  logic                                i_alu1_flush,
    input  logic                                i_alu2_flush,
    rv_stage_if.drv                             o_decode,
    rv_stage_if.drv                             o_alu1,
    rv_stage_if.drv                             o_alu2,
    rv_stage_if.drv                             o_memory,
    rv_stage_if.drv                             o_write,
    rv_stage_if.drv                             o_wr_back
);

    // index 0 is decode, 5 is wr_back
    logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs1_q [0:5];
    logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs2_q [0:5];
    logic [rv_pipe_pkg::REG_ADDR_W-1:0] rd_q  [0:5];
    logic                               reg_write_q [0:5];
    logic                               mem_rd_q    [0:5];
    logic                               inst_sup_q  [0:5];

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int i = 0; i < 6; i++)
            begin
                rs1_q[i]       <= '0;
                rs2_q[i]       <= '0;
                rd_q[i]        <= '0;
                reg_write_q[i] <= 1'b0;
                mem_rd_q[i]    <= 1'b0;
                inst_sup_q[i]  <= 1'b1;             // bubble counts as supported
            end
        end
        else
        begin
            // decode holds under stall, flush wins
            if (i_decode_flush)
            begin
                rs1_q[0]       <= '0;
                rs2_q[0]       <= '0;
                rd_q[0]        <= '0;
                reg_write_q[0] <= 1'b0;
                mem_rd_q[0]    <= 1'b0;
                inst_sup_q[0]  <= 1'b1;
            end
            else if (!i_decode_stall)
            begin
                rs1_q[0]       <= i_fetch_rs1;
                rs2_q[0]       <= i_fetch_rs2;
                rd_q[0]        <= i_fetch_rd;
                reg_write_q[0] <= i_fetch_reg_write;
                mem_rd_q[0]    <= i_fetch_mem_rd;
                inst_sup_q[0]  <= i_fetch_inst_sup;
            end

            if (i_alu1_flush)                       // also set on stall
            begin
                rs1_q[1]       <= '0;
                rs2_q[1]       <= '0;
                rd_q[1]        <= '0;
                reg_write_q[1] <= 1'b0;
                mem_rd_q[1]    <= 1'b0;
                inst_sup_q[1]  <= 1'b1;
            end
            else
            begin
                rs1_q[1]       <= rs1_q[0];
                rs2_q[1]       <= rs2_q[0];
                rd_q[1]        <= rd_q[0];
                reg_write_q[1] <= reg_write_q[0];
                mem_rd_q[1]    <= mem_rd_q[0];
                inst_sup_q[1]  <= inst_sup_q[0];
            end

            if (i_alu2_flush)
            begin
                rs1_q[2]       <= '0;
                rs2_q[2]       <= '0;
                rd_q[2]        <= '0;
                reg_write_q[2] <= 1'b0;
                mem_rd_q[2]    <= 1'b0;
                inst_sup_q[2]  <= 1'b1;
            end
            else
            begin
                rs1_q[2]       <= rs1_q[1];
                rs2_q[2]       <= rs2_q[1];
                rd_q[2]        <= rd_q[1];
                reg_write_q[2] <= reg_write_q[1];
                mem_rd_q[2]    <= mem_rd_q[1];
                inst_sup_q[2]  <= inst_sup_q[1];
            end

            // memory onward never stalls or flushes
            for (int i = 3; i < 6; i++)
            begin
                rs1_q[i]       <= rs1_q[i-1];
                rs2_q[i]       <= rs2_q[i-1];
                rd_q[i]        <= rd_q[i-1];
                reg_write_q[i] <= reg_write_q[i-1];
                mem_rd_q[i]    <= mem_rd_q[i-1];
                inst_sup_q[i]  <= inst_sup_q[i-1];
            end
        end
    end

    assign o_decode.rs1        = rs1_q[0];
    assign o_decode.rs2        = rs2_q[0];
    assign o_decode.rd         = rd_q[0];
    assign o_decode.reg_write  = reg_write_q[0];
    assign o_decode.mem_rd     = mem_rd_q[0];
    assign o_decode.inst_sup   = inst_sup_q[0];

    assign o_alu1.rs1          = rs1_q[1];
    assign o_alu1.rs2          = rs2_q[1];
    assign o_alu1.rd           = rd_q[1];
    assign o_alu1.reg_write    = reg_write_q[1];
    assign o_alu1.mem_rd       = mem_rd_q[1];
    assign o_alu1.inst_sup     = inst_sup_q[1];

    assign o_alu2.rs1          = rs1_q[2];
    assign o_alu2.rs2          = rs2_q[2];
    assign o_alu2.rd           = rd_q[2];
    assign o_alu2.reg_write    = reg_write_q[2];
    assign o_alu2.mem_rd       = mem_rd_q[2];
    assign o_alu2.inst_sup     = inst_sup_q[2];

    assign o_memory.rs1        = rs1_q[3];
    assign o_memory.rs2        = rs2_q[3];
    assign o_memory.rd         = rd_q[3];
    assign o_memory.reg_write  = reg_write_q[3];
    assign o_memory.mem_rd     = mem_rd_q[3];
    assign o_memory.inst_sup   = inst_sup_q[3];

    assign o_write.rs1         = rs1_q[4];
    assign o_write.rs2         = rs2_q[4];
    assign o_write.rd          = rd_q[4];
    assign o_write.reg_write   = reg_write_q[4];
    assign o_write.mem_rd      = mem_rd_q[4];
    assign o_write.inst_sup    = inst_sup_q[4];

    assign o_wr_back.rs1       = rs1_q[5];
    assign o_wr_back.rs2       = rs2_q[5];
    assign o_wr_back.rd        = rd_q[5];
    assign o_wr_back.reg_write = reg_write_q[5];
    assign o_wr_back.mem_rd    = mem_rd_q[5];
    assign o_wr_back.inst_sup  = inst_sup_q[5];

endmodule

// ==== hw/rv_ctrl.sv ====
`timescale 1ns/1ps

module rv_ctrl
(
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_pc_change,
    input  logic                            i_need_pause,
    rv_stage_if.mon                         i_decode,
    rv_stage_if.mon                         i_alu1,
    rv_stage_if.mon                         i_alu2,
    rv_stage_if.mon                         i_memory,
    rv_stage_if.mon                         i_write,
    rv_stage_if.mon                         i_wr_back,
    output logic                            o_fetch_stall,
    output logic                            o_fetch_flush,
    output logic                            o_decode_stall,
    output logic                            o_decode_flush,
    output logic                            o_alu1_flush,
    output logic                            o_alu2_flush,
    output logic [rv_pipe_pkg::BP_W-1:0]    o_rs1_bp,
    output logic [rv_pipe_pkg::BP_W-1:0]    o_rs2_bp,
    output logic                            o_inv_inst
);

    logic       load_use_alu1;
    logic       load_use_alu2;
    logic       stall;
    logic       flush;
    logic [1:0] sup_hist;

    // youngest result stage writing rs with x0 excluded
    function automatic logic [rv_pipe_pkg::BP_W-1:0] fwd_sel
    (
        input logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs
    );
        logic [rv_pipe_pkg::BP_W-1:0] hit;
        hit[rv_pipe_pkg::BP_ALU2]    = i_alu2.reg_write & (|i_alu2.rd) & (rs == i_alu2.rd);
        hit[rv_pipe_pkg::BP_MEMORY]  = i_memory.reg_write & (|i_memory.rd)
                                       & (rs == i_memory.rd);
        hit[rv_pipe_pkg::BP_WRITE]   = i_write.reg_write & (|i_write.rd) & (rs == i_write.rd);
        hit[rv_pipe_pkg::BP_WR_BACK] = i_wr_back.reg_write & (|i_wr_back.rd)
                                       & (rs == i_wr_back.rd);
        // lowest set bit is the youngest stage
        return hit & (~hit + 1'b1);
    endfunction

    // load result not ready yet for a decode source
    assign load_use_alu1 = i_alu1.mem_rd & (|i_alu1.rd)
                           & ((i_decode.rs1 == i_alu1.rd) | (i_decode.rs2 == i_alu1.rd));
    assign load_use_alu2 = i_alu2.mem_rd & (|i_alu2.rd)
                           & ((i_decode.rs1 == i_alu2.rd) | (i_decode.rs2 == i_alu2.rd));

    assign stall = !i_rst_n | load_use_alu1 | load_use_alu2 | i_need_pause;
    assign flush = !i_rst_n | i_pc_change;

    always_ff @(posedge i_clk)
    begin
        if (flush)                                  // covers reset too
            sup_hist <= '1;
        else if (!stall)
            sup_hist <= {sup_hist[0], i_decode.inst_sup};
    end

    assign o_fetch_stall  = stall;
    assign o_fetch_flush  = flush;
    assign o_decode_stall = stall;
    assign o_decode_flush = flush;
    assign o_alu1_flush   = flush | stall;          // bubble behind held decode
    assign o_alu2_flush   = flush;

    always_comb
    begin
        o_rs1_bp = fwd_sel(i_alu1.rs1);
        o_rs2_bp = fwd_sel(i_alu1.rs2);
    end

    assign o_inv_inst = !sup_hist[1];

endmodule

// ==== hw/rv_bypass_mux.sv ====
`timescale 1ns/1ps

module rv_bypass_mux
(
    input  logic [rv_pipe_pkg::BP_W-1:0]    i_rs1_bp,
    input  logic [rv_pipe_pkg::BP_W-1:0]    i_rs2_bp,
    input  logic [rv_pipe_pkg::DATA_W-1:0]  i_rf_rs1_data,
    input  logic [rv_pipe_pkg::DATA_W-1:0]  i_rf_rs2_data,
    input  logic [rv_pipe_pkg::DATA_W-1:0]  i_alu2_result,
    input  logic [rv_pipe_pkg::DATA_W-1:0]  i_memory_result,
    input  logic [rv_pipe_pkg::DATA_W-1:0]  i_write_result,
    input  logic [rv_pipe_pkg::DATA_W-1:0]  i_wr_back_result,
    output logic [rv_pipe_pkg::DATA_W-1:0]  o_alu_op1,
    output logic [rv_pipe_pkg::DATA_W-1:0]  o_alu_op2
);

    // and-or select over a one-hot or zero bp
    function automatic logic [rv_pipe_pkg::DATA_W-1:0] pick
    (
        input logic [rv_pipe_pkg::BP_W-1:0]   bp,
        input logic [rv_pipe_pkg::DATA_W-1:0] rf_data
    );
        logic [rv_pipe_pkg::DATA_W-1:0] res;
        res  = {rv_pipe_pkg::DATA_W{~|bp}} & rf_data;      // no forward
        res |= {rv_pipe_pkg::DATA_W{bp[rv_pipe_pkg::BP_ALU2]}} & i_alu2_result;
        res |= {rv_pipe_pkg::DATA_W{bp[rv_pipe_pkg::BP_MEMORY]}} & i_memory_result;
        res |= {rv_pipe_pkg::DATA_W{bp[rv_pipe_pkg::BP_WRITE]}} & i_write_result;
        res |= {rv_pipe_pkg::DATA_W{bp[rv_pipe_pkg::BP_WR_BACK]}} & i_wr_back_result;
        return res;
    endfunction

    always_comb
    begin
        o_alu_op1 = pick(i_rs1_bp, i_rf_rs1_data);
        o_alu_op2 = pick(i_rs2_bp, i_rf_rs2_data);
    end

endmodule

// ==== hw/rv_hazard_top.sv ====
`timescale 1ns/1ps

module rv_hazard_top
(
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_pc_change,
    input  logic                                i_need_pause,
    input  logic [rv_pipe_pkg::REG_ADDR_W-1:0]  i_fetch_rs1,
    input  logic [rv_pipe_pkg::REG_ADDR_W-1:0]  i_fetch_rs2,
    input  logic [rv_pipe_pkg::REG_ADDR_W-1:0]  i_fetch_rd,
    input  logic                                i_fetch_reg_write,
    input  logic                                i_fetch_mem_rd,
    input  logic                                i_fetch_inst_sup,
    input  logic [rv_pipe_pkg::DATA_W-1:0]      i_rf_rs1_data,
    input  logic [rv_pipe_pkg::DATA_W-1:0]      i_rf_rs2_data,
    input  logic [rv_pipe_pkg::DATA_W-1:0]      i_alu2_result,
    input  logic [rv_pipe_pkg::DATA_W-1:0]      i_memory_result,
    input  logic [rv_pipe_pkg::DATA_W-1:0]      i_write_result,
    input  logic [rv_pipe_pkg::DATA_W-1:0]      i_wr_back_result,
    output logic                                o_fetch_stall,
    output logic                                o_fetch_flush,
    output logic                                o_inv_inst,
    output logic [rv_pipe_pkg::BP_W-1:0]        o_rs1_bp,
    output logic [rv_pipe_pkg::BP_W-1:0]        o_rs2_bp,
    output logic [rv_pipe_pkg::DATA_W-1:0]      o_alu_op1,
    output logic [rv_pipe_pkg::DATA_W-1:0]      o_alu_op2
);

    logic decode_stall;
    logic decode_flush;
    logic alu1_flush;
    logic alu2_flush;

    // one tag bundle per stage
    rv_stage_if decode  ();
    rv_stage_if alu1    ();
    rv_stage_if alu2    ();
    rv_stage_if memory  ();
    rv_stage_if write   ();
    rv_stage_if wr_back ();

    rv_tag_pipe tag_pipe_i
    (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_fetch_rs1       (i_fetch_rs1),
        .i_fetch_rs2       (i_fetch_rs2),
        .i_fetch_rd        (i_fetch_rd),
        .i_fetch_reg_write (i_fetch_reg_write),
        .i_fetch_mem_rd    (i_fetch_mem_rd),
        .i_fetch_inst_sup  (i_fetch_inst_sup),
        .i_decode_stall    (decode_stall),
        .i_decode_flush    (decode_flush),
        .i_alu1_flush      (alu1_flush),
        .i_alu2_flush      (alu2_flush),
        .o_decode          (decode.drv),
        .o_alu1            (alu1.drv),
        .o_alu2            (alu2.drv),
        .o_memory          (memory.drv),
        .o_write           (write.drv),
        .o_wr_back         (wr_back.drv)
    );

    rv_ctrl ctrl_i
    (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_pc_change    (i_pc_change),
        .i_need_pause   (i_need_pause),
        .i_decode       (decode.mon),
        .i_alu1         (alu1.mon),
        .i_alu2         (alu2.mon),
        .i_memory       (memory.mon),
        .i_write        (write.mon),
        .i_wr_back      (wr_back.mon),
        .o_fetch_stall  (o_fetch_stall),
        .o_fetch_flush  (o_fetch_flush),
        .o_decode_stall (decode_stall),
        .o_decode_flush (decode_flush),
        .o_alu1_flush   (alu1_flush),
        .o_alu2_flush   (alu2_flush),
        .o_rs1_bp       (o_rs1_bp),
        .o_rs2_bp       (o_rs2_bp),
        .o_inv_inst     (o_inv_inst)
    );

    rv_bypass_mux bypass_mux_i
    (
        .i_rs1_bp         (o_rs1_bp),
        .i_rs2_bp         (o_rs2_bp),
        .i_rf_rs1_data    (i_rf_rs1_data),
        .i_rf_rs2_data    (i_rf_rs2_data),
        .i_alu2_result    (i_alu2_result),
        .i_memory_result  (i_memory_result),
        .i_write_result   (i_write_result),
        .i_wr_back_result (i_wr_back_result),
        .o_alu_op1        (o_alu_op1),
        .o_alu_op2        (o_alu_op2)
    );

endmodule

// ==== verification/rv_hazard_tb.sv ====
`timescale 1ns/1ps

module rv_hazard_tb;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 5;
    localparam int NUM_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CYCLES + 95;   // 2100 edges

    logic                               clk = 1'b0;
    logic                               rst_n;
    logic                               pc_change;
    logic                               need_pause;
    logic [rv_pipe_pkg::REG_ADDR_W-1:0] fetch_rs1;
    logic [rv_pipe_pkg::REG_ADDR_W-1:0] fetch_rs2;
    logic [rv_pipe_pkg::REG_ADDR_W-1:0] fetch_rd;
    logic                               fetch_reg_write;
    logic                               fetch_mem_rd;
    logic                               fetch_inst_sup;
    logic [rv_pipe_pkg::DATA_W-1:0]     rf_rs1_data;
    logic [rv_pipe_pkg::DATA_W-1:0]     rf_rs2_data;
    logic [rv_pipe_pkg::DATA_W-1:0]     alu2_result;
    logic [rv_pipe_pkg::DATA_W-1:0]     memory_result;
    logic [rv_pipe_pkg::DATA_W-1:0]     write_result;
    logic [rv_pipe_pkg::DATA_W-1:0]     wr_back_result;
    logic                               fetch_stall;
    logic                               fetch_flush;
    logic                               inv_inst;
    logic [rv_pipe_pkg::BP_W-1:0]       rs1_bp;
    logic [rv_pipe_pkg::BP_W-1:0]       rs2_bp;
    logic [rv_pipe_pkg::DATA_W-1:0]     alu_op1;
    logic [rv_pipe_pkg::DATA_W-1:0]     alu_op2;

    // model of the six stage tags, 0 is decode
    logic [rv_pipe_pkg::REG_ADDR_W-1:0] m_rs1 [0:5];
    logic [rv_pipe_pkg::REG_ADDR_W-1:0] m_rs2 [0:5];
    logic [rv_pipe_pkg::REG_ADDR_W-1:0] m_rd  [0:5];
    logic                               m_rw  [0:5];
    logic                               m_ld  [0:5];
    logic                               m_sup [0:5];
    logic [1:0]                         m_hist;

    logic                               exp_stall;
    logic                               exp_flush;
    logic                               exp_inv;
    logic [rv_pipe_pkg::BP_W-1:0]       exp_rs1_bp;
    logic [rv_pipe_pkg::BP_W-1:0]       exp_rs2_bp;
    logic [rv_pipe_pkg::DATA_W-1:0]     exp_op1;
    logic [rv_pipe_pkg::DATA_W-1:0]     exp_op2;

    int cycles = 0;

    rv_hazard_top dut_i
    (
        .i_clk             (clk),
        .i_rst_n           (rst_n),
        .i_pc_change       (pc_change),
        .i_need_pause      (need_pause),
        .i_fetch_rs1       (fetch_rs1),
        .i_fetch_rs2       (fetch_rs2),
        .i_fetch_rd        (fetch_rd),
        .i_fetch_reg_write (fetch_reg_write),
        .i_fetch_mem_rd    (fetch_mem_rd),
        .i_fetch_inst_sup  (fetch_inst_sup),
        .i_rf_rs1_data     (rf_rs1_data),
        .i_rf_rs2_data     (rf_rs2_data),
        .i_alu2_result     (alu2_result),
        .i_memory_result   (memory_result),
        .i_write_result    (write_result),
        .i_wr_back_result  (wr_back_result),
        .o_fetch_stall     (fetch_stall),
        .o_fetch_flush     (fetch_flush),
        .o_inv_inst        (inv_inst),
        .o_rs1_bp          (rs1_bp),
        .o_rs2_bp          (rs2_bp),
        .o_alu_op1         (alu_op1),
        .o_alu_op2         (alu_op2)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s at %0t: got 0x%08h, expected 0x%08h", name, $time, got, exp);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic writes_reg(input int s, input logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs);
        return m_rw[s] && (m_rd[s] != '0) && (m_rd[s] == rs);   // x0 never forwards
    endfunction

    function automatic logic [rv_pipe_pkg::BP_W-1:0] youngest_writer
    (
        input logic [rv_pipe_pkg::REG_ADDR_W-1:0] rs
    );
        logic [rv_pipe_pkg::BP_W-1:0] vec;
        vec = '0;
        if (writes_reg(2, rs))
            vec[rv_pipe_pkg::BP_ALU2] = 1'b1;
        else if (writes_reg(3, rs))
            vec[rv_pipe_pkg::BP_MEMORY] = 1'b1;
        else if (writes_reg(4, rs))
            vec[rv_pipe_pkg::BP_WRITE] = 1'b1;
        else if (writes_reg(5, rs))
            vec[rv_pipe_pkg::BP_WR_BACK] = 1'b1;
        return vec;
    endfunction

    function automatic logic [rv_pipe_pkg::DATA_W-1:0] operand
    (
        input logic [rv_pipe_pkg::BP_W-1:0]   bp,
        input logic [rv_pipe_pkg::DATA_W-1:0] rf_data
    );
        if (bp[rv_pipe_pkg::BP_ALU2])
            return alu2_result;
        else if (bp[rv_pipe_pkg::BP_MEMORY])
            return memory_result;
        else if (bp[rv_pipe_pkg::BP_WRITE])
            return write_result;
        else if (bp[rv_pipe_pkg::BP_WR_BACK])
            return wr_back_result;
        return rf_data;
    endfunction

    function automatic void load_bubble(input int s);
        m_rs1[s] = '0;
        m_rs2[s] = '0;
        m_rd[s]  = '0;
        m_rw[s]  = 1'b0;
        m_ld[s]  = 1'b0;
        m_sup[s] = 1'b1;
    endfunction

    function automatic void shift_stage(input int dst, input int src);
        m_rs1[dst] = m_rs1[src];
        m_rs2[dst] = m_rs2[src];
        m_rd[dst]  = m_rd[src];
        m_rw[dst]  = m_rw[src];
        m_ld[dst]  = m_ld[src];
        m_sup[dst] = m_sup[src];
    endfunction

    // expected outputs for this cycle, then the state after the coming edge
    function automatic void model_step();
        logic ld_use;
        logic stall;
        logic flush;
        ld_use = 1'b0;
        for (int s = 1; s <= 2; s++)
        begin
            if (m_ld[s] && (m_rd[s] != '0) && ((m_rd[s] == m_rs1[0]) || (m_rd[s] == m_rs2[0])))
                ld_use = 1'b1;
        end
        stall      = !rst_n || ld_use || need_pause;
        flush      = !rst_n || pc_change;
        exp_stall  = stall;
        exp_flush  = flush;
        exp_rs1_bp = youngest_writer(m_rs1[1]);
        exp_rs2_bp = youngest_writer(m_rs2[1]);
        exp_op1    = operand(exp_rs1_bp, rf_rs1_data);
        exp_op2    = operand(exp_rs2_bp, rf_rs2_data);
        exp_inv    = !m_hist[1];

        if (flush)
            m_hist = 2'b11;
        else if (!stall)
            m_hist = {m_hist[0], m_sup[0]};
        for (int s = 5; s >= 3; s--)
            shift_stage(s, s - 1);
        if (flush)
            load_bubble(2);
        else
            shift_stage(2, 1);
        if (flush || stall)
            load_bubble(1);                         // bubble behind held decode
        else
            shift_stage(1, 0);
        if (flush)
            load_bubble(0);
        else if (!stall)
        begin
            m_rs1[0] = fetch_rs1;
            m_rs2[0] = fetch_rs2;
            m_rd[0]  = fetch_rd;
            m_rw[0]  = fetch_reg_write;
            m_ld[0]  = fetch_mem_rd;
            m_sup[0] = fetch_inst_sup;
        end
        if (!rst_n)
        begin
            for (int s = 0; s < 6; s++)
                load_bubble(s);
        end
    endfunction

    task automatic drive_inputs(input logic hold_tag);
        logic [31:0] r;
        r = $urandom;
        if (!hold_tag)
        begin
            fetch_rs1       = '0;
            fetch_rs1[2:0]  = r[2:0];               // x0 to x7 only
            fetch_rs2       = '0;
            fetch_rs2[2:0]  = r[5:3];
            fetch_rd        = '0;
            fetch_rd[2:0]   = r[8:6];
            fetch_mem_rd    = (r[10:9] == 2'b00);
            fetch_reg_write = fetch_mem_rd || (r[12:11] != 2'b00);
            fetch_inst_sup  = ($urandom_range(99, 0) >= 32'd3);
        end
        pc_change      = ($urandom_range(99, 0) < 32'd5);
        need_pause     = ($urandom_range(99, 0) < 32'd5);
        rf_rs1_data    = $urandom;
        rf_rs2_data    = $urandom;
        alu2_result    = $urandom;
        memory_result  = $urandom;
        write_result   = $urandom;
        wr_back_result = $urandom;
    endtask

    initial
    begin
        logic hold_tag;
        void'($urandom(63));
        rst_n           = 1'b0;
        pc_change       = 1'b0;
        need_pause      = 1'b0;
        fetch_rs1       = '0;
        fetch_rs2       = '0;
        fetch_rd        = '0;
        fetch_reg_write = 1'b0;
        fetch_mem_rd    = 1'b0;
        fetch_inst_sup  = 1'b1;
        rf_rs1_data     = '0;
        rf_rs2_data     = '0;
        alu2_result     = '0;
        memory_result   = '0;
        write_result    = '0;
        wr_back_result  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        drive_inputs(1'b0);
        pc_change  = 1'b0;                          // clean first cycle after reset
        need_pause = 1'b0;
        forever
        begin
            @(negedge clk);
            hold_tag = fetch_stall;                 // stall seen by the coming edge
            @(posedge clk);
            #1;
            drive_inputs(hold_tag);
        end
    end

    initial
    begin
        int checked;
        checked = 0;
        while (checked < NUM_CYCLES)
        begin
            @(posedge clk);
            #(CLK_PERIOD - 2);
            model_step();
            if (!rst_n)
            begin
                check_value("o_fetch_stall", 32'(fetch_stall), 32'd1);
                check_value("o_fetch_flush", 32'(fetch_flush), 32'd1);
            end
            else
            begin
                if (checked == 0)
                begin
                    check_value("o_fetch_stall", 32'(fetch_stall), 32'd0);
                    check_value("o_fetch_flush", 32'(fetch_flush), 32'd0);
                    check_value("o_rs1_bp", 32'(rs1_bp), 32'd0);
                    check_value("o_rs2_bp", 32'(rs2_bp), 32'd0);
                    check_value("o_inv_inst", 32'(inv_inst), 32'd0);
                end
                check_value("o_fetch_stall", 32'(fetch_stall), 32'(exp_stall));
                check_value("o_fetch_flush", 32'(fetch_flush), 32'(exp_flush));
                check_value("o_rs1_bp one-hot", 32'($onehot0(rs1_bp)), 32'd1);
                check_value("o_rs2_bp one-hot", 32'($onehot0(rs2_bp)), 32'd1);
                check_value("o_rs1_bp", 32'(rs1_bp), 32'(exp_rs1_bp));
                check_value("o_rs2_bp", 32'(rs2_bp), 32'(exp_rs2_bp));
                check_value("o_alu_op1", alu_op1, exp_op1);
                check_value("o_alu_op2", alu_op2, exp_op2);
                check_value("o_inv_inst", 32'(inv_inst), 32'(exp_inv));
                checked++;
            end
        end
        $display("No errors");
        $finish;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

endmodule

// ==== rv_hazard.f ====
hw/rv_pipe_pkg.sv
hw/rv_stage_if.sv
hw/rv_tag_pipe.sv
hw/rv_ctrl.sv
hw/rv_bypass_mux.sv
hw/rv_hazard_top.sv
verification/rv_hazard_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := rv_hazard_tb
FILELIST  := rv_hazard.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run check clean

all: check

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	@grep -qx "No errors" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
